// ==== bpu_config.svh ====
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// unconditional branch opcodes, register and immediate forms
`define BPU_OP_BRU 6'o46
`define BPU_OP_BRUI 6'o56

// conditional branch opcodes
`define BPU_OP_BCC 6'o47
`define BPU_OP_BCCI 6'o57

// condition codes carried in rd[2:0]
`define BPU_CC_EQ 3'd0
`define BPU_CC_NE 3'd1
`define BPU_CC_LT 3'd2
`define BPU_CC_LE 3'd3
`define BPU_CC_GT 3'd4
`define BPU_CC_GE 3'd5

// word address after reset
`define BPU_RESET_PC 30'd0

// extra cycles the testbench waits past the run length
`define BPU_TIMEOUT_MARGIN 200

`endif

// ==== bpuPkg.sv ====
package bpuPkg;

  // instruction word as it arrives from decode
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rd;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [10:0] alt;
  } instrWord_t;

  // word-aligned program counter, byte address bits 31:2
  typedef logic [31:2] pcWord_t;

  // branch operand source
  typedef enum logic [1:0] {
    regA = 2'd0,
    aluFwd = 2'd1,
    ioFwd = 2'd2
  } fwdSel_t;

  // decode controls held for the execute cycle
  typedef struct packed {
    // latched instruction is a branch at all
    logic isBranch;
    // taken regardless of operand
    logic uncond;
    // zero and sign tests in use
    logic careZero;
    logic careSign;
    // expected results of those tests
    logic wantZero;
    logic wantSign;
    // flip the combined answer, used for gt and ge
    logic invert;
    // the following instruction executes
    logic delaySlot;
  } condCtl_t;

  // branch decision handed to fetch
  typedef struct packed {
    logic taken;
    logic delaySlot;
  } verdict_t;

endpackage

// ==== branchCond.sv ====
`timescale 1ns/1ps

`include "bpu_config.svh"

module branchCond
  import bpuPkg::*;
(
  input logic gclk,
  input logic grst,
  input logic decodeEn,
  input instrWord_t instr,
  input fwdSel_t fwdSel,
  input logic [31:0] regA,
  input logic [31:0] aluResult,
  input logic [31:0] ioReg,
  input logic irq,
  input logic dSkip,
  output verdict_t verdict
);

  // operand candidate picked by the forwarding select
  logic [31:0] opSel;
  // decoded controls for the instruction in decode now
  condCtl_t decodeCtl;
  // opcode classes
  logic isBru;
  logic isBcc;
  logic [2:0] ccode;

  // latched state used during execute
  logic [31:0] opLatch;
  condCtl_t ctlLatch;

  // operand tests
  logic opZero;
  logic opNeg;
  logic zeroHit;
  logic signHit;
  logic condTrue;

  assign isBru = (instr.opcode == `BPU_OP_BRU) || (instr.opcode == `BPU_OP_BRUI);
  assign isBcc = (instr.opcode == `BPU_OP_BCC) || (instr.opcode == `BPU_OP_BCCI);
  assign ccode = instr.rd[2:0];

  // forwarding mux
  always_comb begin
    case (fwdSel)
      aluFwd: opSel = aluResult;
      ioFwd: opSel = ioReg;
      // plain register-file read
      default: opSel = regA;
    endcase
  end

  // opcode and condition decode
  always_comb begin
    decodeCtl = '0;
    if (irq) begin
      // interrupt forces a branch, never with a delay slot
      decodeCtl.isBranch = 1'b1;
      decodeCtl.uncond = 1'b1;
    end else if (isBru) begin
      decodeCtl.isBranch = 1'b1;
      decodeCtl.uncond = 1'b1;
      // delay bit lives in ra for br
      decodeCtl.delaySlot = instr.ra[4];
    end else if (isBcc) begin
      decodeCtl.isBranch = 1'b1;
      // delay bit lives in rd for bcc
      decodeCtl.delaySlot = instr.rd[4];
      case (ccode)
        `BPU_CC_EQ: begin
          decodeCtl.careZero = 1'b1;
          decodeCtl.wantZero = 1'b1;
        end
        `BPU_CC_NE: begin
          decodeCtl.careZero = 1'b1;
        end
        `BPU_CC_LT: begin
          decodeCtl.careSign = 1'b1;
          decodeCtl.wantSign = 1'b1;
        end
        `BPU_CC_LE: begin
          decodeCtl.careZero = 1'b1;
          decodeCtl.wantZero = 1'b1;
          decodeCtl.careSign = 1'b1;
          decodeCtl.wantSign = 1'b1;
        end
        // gt is le inverted
        `BPU_CC_GT: begin
          decodeCtl.careZero = 1'b1;
          decodeCtl.wantZero = 1'b1;
          decodeCtl.careSign = 1'b1;
          decodeCtl.wantSign = 1'b1;
          decodeCtl.invert = 1'b1;
        end
        // ge is lt inverted
        `BPU_CC_GE: begin
          decodeCtl.careSign = 1'b1;
          decodeCtl.wantSign = 1'b1;
          decodeCtl.invert = 1'b1;
        end
        // undefined codes never branch
        default: decodeCtl = '0;
      endcase
    end
  end

  // decode stage latch
  always_ff @(posedge gclk) begin
    if (grst) begin
      opLatch <= '0;
      ctlLatch <= '0;
    end else if (decodeEn) begin
      opLatch <= opSel;
      // squashed slot after a taken branch, load a no-branch control
      if (dSkip) begin
        ctlLatch <= '0;
      end else begin
        ctlLatch <= decodeCtl;
      end
    end
  end

  assign opZero = (opLatch == 32'd0);
  assign opNeg = opLatch[31];

  // le needs either test to hit, so the two are or-ed
  assign zeroHit = ctlLatch.careZero && (opZero == ctlLatch.wantZero);
  assign signHit = ctlLatch.careSign && (opNeg == ctlLatch.wantSign);
  assign condTrue = (zeroHit || signHit) ^ ctlLatch.invert;

  assign verdict.taken = ctlLatch.isBranch && (ctlLatch.uncond || condTrue);
  assign verdict.delaySlot = ctlLatch.delaySlot;

endmodule

// ==== pcTrack.sv ====
`timescale 1ns/1ps

`include "bpu_config.svh"

module pcTrack
  import bpuPkg::*;
(
  input logic gclk,
  input logic grst,
  input logic execEn,
  input logic seqStep,
  input pcWord_t nextFetch,
  output pcWord_t seqAddr,
  output pcWord_t fetchPc,
  output pcWord_t decodePc,
  output pcWord_t linkPc
);

  // address handed to the cache one stage ahead of fetch
  pcWord_t preFetch;
  // step widened to the counter width
  pcWord_t stepWord;

  assign stepWord = {29'd0, seqStep};

  // sequential candidate, only advances when the fetch consumed a word
  assign seqAddr = preFetch + stepWord;

  // all four stages move on the same execute strobe
  always_ff @(posedge gclk) begin
    if (grst) begin
      preFetch <= `BPU_RESET_PC;
      fetchPc <= `BPU_RESET_PC;
      decodePc <= `BPU_RESET_PC;
      linkPc <= `BPU_RESET_PC;
    end else if (execEn) begin
      preFetch <= nextFetch;
      fetchPc <= preFetch;
      decodePc <= fetchPc;
      // link value for brl style writes
      linkPc <= decodePc;
    end
  end

endmodule

// ==== fetchSteer.sv ====
`timescale 1ns/1ps

module fetchSteer
  import bpuPkg::*;
(
  input logic gclk,
  input logic grst,
  input logic execEn,
  input verdict_t verdict,
  input pcWord_t seqAddr,
  input logic [31:0] aluResult,
  output pcWord_t nextFetch,
  output logic [31:0] fetchAddr,
  output logic dSkip,
  output logic xSkip
);

  // branch target from the alu, word part only
  pcWord_t target;

  assign target = aluResult[31:2];

  // taken branch wins over the sequential path
  assign nextFetch = verdict.taken ? target : seqAddr;

  // byte address toward the cache
  assign fetchAddr = {nextFetch, 2'b00};

  // no delay slot means the next instruction must not run
  assign dSkip = verdict.taken && !verdict.delaySlot;

  // squash follows the instruction into execute
  always_ff @(posedge gclk) begin
    if (grst) begin
      xSkip <= 1'b0;
    end else if (execEn) begin
      xSkip <= dSkip;
    end
  end

endmodule

// ==== branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit
  import bpuPkg::*;
(
  input logic gclk,
  input logic grst,
  input logic decodeEn,
  input logic execEn,
  input instrWord_t instr,
  input fwdSel_t fwdSel,
  input logic [31:0] regA,
  input logic [31:0] aluResult,
  input logic [31:0] ioReg,
  input logic seqStep,
  input logic irq,
  output logic [31:0] fetchAddr,
  output pcWord_t fetchPc,
  output pcWord_t decodePc,
  output pcWord_t linkPc,
  output logic dSkip,
  output logic xSkip
);

  // decision from the condition block
  verdict_t verdict;
  // sequential candidate from the pc pipeline
  pcWord_t seqAddr;
  // chosen address fed back into the pipeline
  pcWord_t nextFetch;

  // operand latch and taken evaluation
  branchCond uCond (
    .gclk(gclk),
    .grst(grst),
    .decodeEn(decodeEn),
    .instr(instr),
    .fwdSel(fwdSel),
    .regA(regA),
    .aluResult(aluResult),
    .ioReg(ioReg),
    .irq(irq),
    .dSkip(dSkip),
    .verdict(verdict)
  );

  // program counter stages
  pcTrack uTrack (
    .gclk(gclk),
    .grst(grst),
    .execEn(execEn),
    .seqStep(seqStep),
    .nextFetch(nextFetch),
    .seqAddr(seqAddr),
    .fetchPc(fetchPc),
    .decodePc(decodePc),
    .linkPc(linkPc)
  );

  // next address select and squash flags
  fetchSteer uSteer (
    .gclk(gclk),
    .grst(grst),
    .execEn(execEn),
    .verdict(verdict),
    .seqAddr(seqAddr),
    .aluResult(aluResult),
    .nextFetch(nextFetch),
    .fetchAddr(fetchAddr),
    .dSkip(dSkip),
    .xSkip(xSkip)
  );

endmodule

// ==== branchUnit_checker.sv ====
`timescale 1ns/1ps

module branchUnitChecker
  import bpuPkg::*;
(
  input logic gclk,
  input logic grst,
  input logic execEn,
  input logic dSkip,
  input logic xSkip,
  input logic [31:0] aluResult,
  input logic [31:0] fetchAddr,
  input pcWord_t decodePc,
  input pcWord_t linkPc
);

  // number of failed assertions for the testbench summary
  int failCount = 0;

  // squash only while fetch is steered to the branch target
  skipNeedsTaken: assert property (@(posedge gclk) disable iff (grst)
    dSkip |-> (fetchAddr == {aluResult[31:2], 2'b00}))
    else begin
      $error("dSkip high while fetch is not steered to the branch target");
      failCount++;
    end

  // both squash flags clear right after a reset edge
  resetClearsSkip: assert property (@(posedge gclk)
    grst |=> (!dSkip && !xSkip))
    else begin
      $error("skip flags not low in the cycle after reset");
      failCount++;
    end

  // link stage is decode delayed by one execute strobe
  linkFollowsDecode: assert property (@(posedge gclk) disable iff (grst)
    execEn |=> (linkPc == $past(decodePc)))
    else begin
      $error("linkPc did not take the previous decodePc");
      failCount++;
    end

endmodule

bind branchUnit branchUnitChecker chk (
  .gclk(gclk),
  .grst(grst),
  .execEn(execEn),
  .dSkip(dSkip),
  .xSkip(xSkip),
  .aluResult(aluResult),
  .fetchAddr(fetchAddr),
  .decodePc(decodePc),
  .linkPc(linkPc)
);

// ==== branchUnitMonitor.sv ====
`timescale 1ns/1ps

`include "bpu_config.svh"

module branchUnitMonitor
  import bpuPkg::*;
(
  input logic gclk,
  input logic grst,
  input logic decodeEn,
  input logic execEn,
  input instrWord_t instr,
  input fwdSel_t fwdSel,
  input logic [31:0] regA,
  input logic [31:0] aluResult,
  input logic [31:0] ioReg,
  input logic seqStep,
  input logic irq,
  input logic [31:0] fetchAddr,
  input pcWord_t fetchPc,
  input pcWord_t decodePc,
  input pcWord_t linkPc,
  input logic dSkip,
  input logic xSkip,
  output int errCount,
  output int checkCount
);

  // model of the decode latch
  logic [31:0] mOp;
  logic mBranch;
  logic mUncond;
  logic mDelay;
  logic [2:0] mCc;
  // model of the pc stages
  pcWord_t mPre;
  pcWord_t mFetch;
  pcWord_t mDecode;
  pcWord_t mLink;
  logic mXSkip;
  logic started = 1'b0;
  int errTotal = 0;
  int checkTotal = 0;

  logic expTaken;
  logic expDSkip;
  pcWord_t expNext;

  // condition table straight from the branch rules
  function automatic logic condMet(input logic [2:0] cc, input logic [31:0] op);
    logic isZero;
    logic isNeg;
    isZero = (op == 32'd0);
    isNeg = op[31];
    case (cc)
      `BPU_CC_EQ: condMet = isZero;
      `BPU_CC_NE: condMet = !isZero;
      `BPU_CC_LT: condMet = isNeg;
      `BPU_CC_LE: condMet = isNeg || isZero;
      `BPU_CC_GT: condMet = !(isNeg || isZero);
      `BPU_CC_GE: condMet = !isNeg;
      default: condMet = 1'b0;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkTotal++;
    if (got !== exp) begin
      errTotal++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  assign expTaken = mBranch && (mUncond || condMet(mCc, mOp));
  assign expDSkip = expTaken && !mDelay;
  assign expNext = expTaken ? aluResult[31:2] : mPre + 30'(seqStep);
  assign errCount = errTotal;
  assign checkCount = checkTotal;

  // sample inputs at the edge, inputs are stable there
  always @(posedge gclk) begin
    logic isUncond;
    logic isCond;
    logic [31:0] pick;
    // irq turns anything into br
    isUncond = irq || (instr.opcode == `BPU_OP_BRU) || (instr.opcode == `BPU_OP_BRUI);
    isCond = (instr.opcode == `BPU_OP_BCC) || (instr.opcode == `BPU_OP_BCCI);
    case (fwdSel)
      aluFwd: pick = aluResult;
      ioFwd: pick = ioReg;
      default: pick = regA;
    endcase
    if (grst) begin
      mOp <= '0;
      mBranch <= 1'b0;
      mUncond <= 1'b0;
      mDelay <= 1'b0;
      mCc <= '0;
      mPre <= '0;
      mFetch <= '0;
      mDecode <= '0;
      mLink <= '0;
      mXSkip <= 1'b0;
      started <= 1'b1;
    end else begin
      if (decodeEn) begin
        mOp <= pick;
        // squashed slot never branches
        mBranch <= (isUncond || isCond) && !expDSkip;
        mUncond <= isUncond;
        mCc <= instr.rd[2:0];
        mDelay <= irq ? 1'b0 : (isUncond ? instr.ra[4] : instr.rd[4]);
      end
      if (execEn) begin
        mPre <= expNext;
        mFetch <= mPre;
        mDecode <= mFetch;
        mLink <= mDecode;
        mXSkip <= expDSkip;
      end
    end
  end

  // compare mid-cycle, away from both the edge and the input change
  always @(negedge gclk) begin
    if (started) begin
      checkValue("fetchAddr", fetchAddr, {expNext, 2'b00});
      checkValue("fetchPc", {2'b00, fetchPc}, {2'b00, mFetch});
      checkValue("decodePc", {2'b00, decodePc}, {2'b00, mDecode});
      checkValue("linkPc", {2'b00, linkPc}, {2'b00, mLink});
      checkValue("dSkip", {31'd0, dSkip}, {31'd0, expDSkip});
      checkValue("xSkip", {31'd0, xSkip}, {31'd0, mXSkip});
    end
  end

endmodule

// ==== branchUnit_tb.sv ====
`timescale 1ns/1ps

`include "bpu_config.svh"

module branchUnit_tb
  import bpuPkg::*;
();

  localparam int runCycles = 3000;
  localparam int resetCycles = 4;
  // reset plus random run, margin covers the drain at the end
  localparam int cycleLimit = runCycles + resetCycles + `BPU_TIMEOUT_MARGIN;

  logic gclk;
  logic grst;
  logic decodeEn;
  logic execEn;
  instrWord_t instr;
  fwdSel_t fwdSel;
  logic [31:0] regA;
  logic [31:0] aluResult;
  logic [31:0] ioReg;
  logic seqStep;
  logic irq;
  logic [31:0] fetchAddr;
  pcWord_t fetchPc;
  pcWord_t decodePc;
  pcWord_t linkPc;
  logic dSkip;
  logic xSkip;
  int errCount;
  int checkCount;
  int cycleCount;

  branchUnit uut (
    .gclk(gclk),
    .grst(grst),
    .decodeEn(decodeEn),
    .execEn(execEn),
    .instr(instr),
    .fwdSel(fwdSel),
    .regA(regA),
    .aluResult(aluResult),
    .ioReg(ioReg),
    .seqStep(seqStep),
    .irq(irq),
    .fetchAddr(fetchAddr),
    .fetchPc(fetchPc),
    .decodePc(decodePc),
    .linkPc(linkPc),
    .dSkip(dSkip),
    .xSkip(xSkip)
  );

  branchUnitMonitor mon (
    .gclk(gclk),
    .grst(grst),
    .decodeEn(decodeEn),
    .execEn(execEn),
    .instr(instr),
    .fwdSel(fwdSel),
    .regA(regA),
    .aluResult(aluResult),
    .ioReg(ioReg),
    .seqStep(seqStep),
    .irq(irq),
    .fetchAddr(fetchAddr),
    .fetchPc(fetchPc),
    .decodePc(decodePc),
    .linkPc(linkPc),
    .dSkip(dSkip),
    .xSkip(xSkip),
    .errCount(errCount),
    .checkCount(checkCount)
  );

  // 8 ns clock
  initial begin
    gclk = 1'b0;
    forever #4 gclk = ~gclk;
  end

  // zero and negative values come up often
  function automatic logic [31:0] randOperand();
    int pick;
    pick = int'($urandom % 4);
    case (pick)
      0: randOperand = 32'd0;
      1: randOperand = $urandom | 32'h8000_0000;
      default: randOperand = $urandom;
    endcase
  endfunction

  // mostly branch opcodes, some random filler
  function automatic logic [5:0] randOpcode();
    int pick;
    pick = int'($urandom % 10);
    case (pick)
      0: randOpcode = `BPU_OP_BRU;
      1: randOpcode = `BPU_OP_BRUI;
      2, 3: randOpcode = `BPU_OP_BCC;
      4, 5: randOpcode = `BPU_OP_BCCI;
      default: randOpcode = 6'($urandom);
    endcase
  endfunction

  task automatic driveInputs();
    int sel;
    instr.opcode = randOpcode();
    instr.rd = 5'($urandom);
    // only the defined condition codes
    instr.rd[2:0] = 3'($urandom % 6);
    instr.ra = 5'($urandom);
    instr.rb = 5'($urandom);
    instr.alt = 11'($urandom);
    sel = int'($urandom % 3);
    case (sel)
      1: fwdSel = bpuPkg::aluFwd;
      2: fwdSel = bpuPkg::ioFwd;
      default: fwdSel = bpuPkg::regA;
    endcase
    regA = randOperand();
    aluResult = randOperand();
    ioReg = randOperand();
    decodeEn = ($urandom % 4) != 0;
    execEn = ($urandom % 4) != 0;
    seqStep = ($urandom % 4) != 0;
    // irq kept rare
    irq = ($urandom % 32) == 0;
  endtask

  // cycle watchdog
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge gclk);
      cycleCount++;
    end
    $display("timeout, run did not finish within %0d cycles", cycleLimit);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    void'($urandom(32'h97f7));
    grst = 1'b1;
    decodeEn = 1'b0;
    execEn = 1'b0;
    instr = '0;
    fwdSel = bpuPkg::regA;
    regA = 32'd0;
    aluResult = 32'd0;
    ioReg = 32'd0;
    seqStep = 1'b0;
    irq = 1'b0;
    repeat (resetCycles) @(posedge gclk);
    #1;
    grst = 1'b0;
    // inputs move 1 ns after each edge
    for (int i = 0; i < runCycles; i++) begin
      driveInputs();
      @(posedge gclk);
      #1;
    end
    decodeEn = 1'b0;
    execEn = 1'b0;
    // let the last cycles be compared
    @(negedge gclk);
    @(negedge gclk);
    $display("closing: %0d checks, %0d value errors, %0d assertion failures",
             checkCount, errCount, uut.chk.failCount);
    if (errCount == 0 && uut.chk.failCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== branchUnit.f ====
+incdir+.
bpuPkg.sv
branchCond.sv
pcTrack.sv
fetchSteer.sv
branchUnit.sv
branchUnit_checker.sv
branchUnitMonitor.sv
branchUnit_tb.sv

// ==== Makefile ====
# Verilator build and run for the branch unit testbench

VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = branchUnit_tb
FILELIST = branchUnit.f
OBJDIR = obj_dir
BIN = $(OBJDIR)/simv
LOG = sim.log
RUNFLAGS = +verilator+error+limit+1000
FAIL_MSG = ERRORS FOUND
PASS_MSG = NO ERRORS

SRCS := $(shell grep -v '^+' $(FILELIST)) bpu_config.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o simv

run: $(BIN)
	-./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
